/* design/mem_stage_pkg.sv */
package mem_stage_pkg;

   ////////////////////
   // Word geometry.
   ////////////////////

   // Data word width.
   localparam int WORD_BITS = 32;

   // Lane widths derived from the word.
   localparam int HALF_BITS = WORD_BITS / 2;
   localparam int BYTE_BITS = 8;
   localparam int BYTE_LANES = WORD_BITS / BYTE_BITS;

   ////////////////////
   // Access select code.
   ////////////////////

   // Width of the select code driven by decode.
   localparam int SELECT_BITS = 3;

   // Size field in bits 1:0.
   // Code 2 is not a legal size.
   localparam logic [1:0] SEL_SIZE_BYTE = 2'd0;
   localparam logic [1:0] SEL_SIZE_HALF = 2'd1;
   localparam logic [1:0] SEL_SIZE_WORD = 2'd3;

   // Bit 2 asks for zero extension on loads.
   localparam int SEL_UNSIGNED_BIT = 2;

   // Select code held after a soft reset.
   // Signed word access.
   localparam logic [SELECT_BITS-1:0] SEL_RESET = {1'b0, SEL_SIZE_WORD};

   // One memory word seen as a word, two halves or four bytes.
   // Index 0 is the least significant lane in both lane views.
   typedef union packed {
      logic [WORD_BITS-1:0] word;
      logic [1:0][HALF_BITS-1:0] halves;
      logic [BYTE_LANES-1:0][BYTE_BITS-1:0] bytes;
   } mem_word_u;

endpackage

/* design/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
   parameter int RAM_DEPTH = 1024
) (
   input  logic                                     i_clock,
   input  logic                                     i_soft_reset,
   // Word index, the byte address with bits 1:0 dropped.
   input  logic [$clog2(RAM_DEPTH)-1:0]             i_word_index,
   // Store word already steered into its lanes.
   input  mem_stage_pkg::mem_word_u                 i_write_word,
   input  logic [mem_stage_pkg::BYTE_LANES-1:0]     i_byte_enable,
   // Strobes arrive already gated by the pipeline enable.
   input  logic                                     i_write_strobe,
   input  logic                                     i_read_strobe,
   // Registered read word.
   output mem_stage_pkg::mem_word_u                 o_read_word
);

   // Lane width used for slicing the array words.
   localparam int LANE_BITS = mem_stage_pkg::BYTE_BITS;

   // Word storage of RAM_DEPTH entries.
   // Contents persist across a soft reset.
   logic [mem_stage_pkg::WORD_BITS-1:0] ram [RAM_DEPTH];

   ////////////////////
   // Write port.
   ////////////////////

   // Only the enabled byte lanes of the addressed word change.
   // The other lanes keep their old value.
   always_ff @(posedge i_clock) begin
      if (i_write_strobe) begin
         for (int lane = 0; lane < mem_stage_pkg::BYTE_LANES; lane++) begin
            if (i_byte_enable[lane]) begin
               ram[i_word_index][lane*LANE_BITS +: LANE_BITS] <=
                  i_write_word.word[lane*LANE_BITS +: LANE_BITS];
            end
         end
      end
   end

   ////////////////////
   // Read port.
   ////////////////////

   // Addressed word is captured one edge after the read strobe.
   // Between loads the register holds the last word read.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_read_word.word <= '0;
      end else if (i_read_strobe) begin
         o_read_word.word <= ram[i_word_index];
      end
   end

   // One access per cycle.
   // A read and a write together would mean decode sent a bad pair.
   a_strobe_exclusive: assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      !(i_write_strobe && i_read_strobe)
   ) else $error("data_memory: read and write strobes high together");

endmodule

/* design/dirty_bit_tracker.sv */
`timescale 1ns/1ps

module dirty_bit_tracker #(
   parameter int RAM_DEPTH = 1024
) (
   input  logic                          i_clock,
   input  logic                          i_soft_reset,
   // Same index the RAM sees.
   input  logic [$clog2(RAM_DEPTH)-1:0]  i_word_index,
   input  logic                          i_write_strobe,
   input  logic                          i_read_strobe,
   // Dirty state of the last accessed word before that access.
   output logic                          o_dirty
);

   // One bit per RAM word.
   // Set when the word is written since the last soft reset.
   logic [RAM_DEPTH-1:0] dirty_bits;

   // Any access to the word, read or write.
   logic access;

   assign access = i_write_strobe | i_read_strobe;

   // Soft reset clears the whole vector in a single cycle.
   // The reported bit is sampled before a write can set it.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty_bits <= '0;
         o_dirty <= 1'b0;
      end else begin
         if (access) begin
            o_dirty <= dirty_bits[i_word_index];
         end
         if (i_write_strobe) begin
            dirty_bits[i_word_index] <= 1'b1;
         end
      end
   end

   // The written word reads back as dirty on the following cycle.
   a_dirty_after_write: assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      i_write_strobe |=> dirty_bits[$past(i_word_index)]
   ) else $error("dirty_bit_tracker: written word not marked dirty");

endmodule

/* design/byte_lane_unit.sv */
`timescale 1ns/1ps

module byte_lane_unit (
   // Store side, straight from the stage inputs.
   input  logic [mem_stage_pkg::WORD_BITS-1:0]    i_store_data,
   input  logic [1:0]                             i_store_offset,
   input  logic [mem_stage_pkg::SELECT_BITS-1:0]  i_store_select,
   output mem_stage_pkg::mem_word_u               o_write_word,
   output logic [mem_stage_pkg::BYTE_LANES-1:0]   o_byte_enable,
   // Load side, from the registered word and stage register.
   input  mem_stage_pkg::mem_word_u               i_read_word,
   input  logic [1:0]                             i_load_offset,
   input  logic [mem_stage_pkg::SELECT_BITS-1:0]  i_load_select,
   output logic [mem_stage_pkg::WORD_BITS-1:0]    o_load_data
);

   // Extension widths for byte and half loads.
   localparam int BYTE_PAD = mem_stage_pkg::WORD_BITS - mem_stage_pkg::BYTE_BITS;
   localparam int HALF_PAD = mem_stage_pkg::WORD_BITS - mem_stage_pkg::HALF_BITS;

   // Selected load lanes before extension.
   logic [mem_stage_pkg::BYTE_BITS-1:0] load_byte;
   logic [mem_stage_pkg::HALF_BITS-1:0] load_half;

   // Fill bits for the upper part of a narrow load.
   logic byte_fill;
   logic half_fill;

   ////////////////////
   // Store steering.
   ////////////////////

   // Low part of the store data goes to the lane picked by the offset.
   // Unused lanes stay zero and are masked by the enables.
   always_comb begin
      o_write_word = '0;
      o_byte_enable = '0;
      case (i_store_select[1:0])
         mem_stage_pkg::SEL_SIZE_BYTE: begin
            o_write_word.bytes[i_store_offset] = i_store_data[mem_stage_pkg::BYTE_BITS-1:0];
            o_byte_enable[i_store_offset] = 1'b1;
         end
         mem_stage_pkg::SEL_SIZE_HALF: begin
            o_write_word.halves[i_store_offset[1]] =
               i_store_data[mem_stage_pkg::HALF_BITS-1:0];
            o_byte_enable = i_store_offset[1] ? 4'b1100 : 4'b0011;
         end
         mem_stage_pkg::SEL_SIZE_WORD: begin
            o_write_word.word = i_store_data;
            o_byte_enable = '1;
         end
         // Illegal size writes nothing.
         default: begin
            o_byte_enable = '0;
         end
      endcase
   end

   ////////////////////
   // Load extraction.
   ////////////////////

   assign load_byte = i_read_word.bytes[i_load_offset];
   assign load_half = i_read_word.halves[i_load_offset[1]];

   // Top bit of the lane for signed loads, zero for unsigned.
   assign byte_fill = ~i_load_select[mem_stage_pkg::SEL_UNSIGNED_BIT] &
                      load_byte[mem_stage_pkg::BYTE_BITS-1];
   assign half_fill = ~i_load_select[mem_stage_pkg::SEL_UNSIGNED_BIT] &
                      load_half[mem_stage_pkg::HALF_BITS-1];

   always_comb begin
      case (i_load_select[1:0])
         mem_stage_pkg::SEL_SIZE_BYTE: o_load_data = {{BYTE_PAD{byte_fill}}, load_byte};
         mem_stage_pkg::SEL_SIZE_HALF: o_load_data = {{HALF_PAD{half_fill}}, load_half};
         default:                      o_load_data = i_read_word.word;
      endcase
   end

   // Load offset and select are the values captured with the last load.
   // They must describe an aligned, legal access.
   always_comb begin
      a_load_size_legal: assert (i_load_select[1:0] != 2'd2)
         else $error("byte_lane_unit: size code 2 on load");
      a_load_half_aligned: assert (i_load_select[1:0] != mem_stage_pkg::SEL_SIZE_HALF ||
                                   !i_load_offset[0])
         else $error("byte_lane_unit: misaligned half load");
      a_load_word_aligned: assert (i_load_select[1:0] != mem_stage_pkg::SEL_SIZE_WORD ||
                                   i_load_offset == 2'b00)
         else $error("byte_lane_unit: misaligned word load");
   end

endmodule

/* design/top_mem.sv */
`timescale 1ns/1ps

module top_mem #(
   parameter int RAM_DEPTH = 1024,
   parameter int CANT_REGISTROS = 32
) (
   input  logic                                     i_clock,
   input  logic                                     i_soft_reset,
   // Stall control. Low freezes the whole stage.
   input  logic                                     i_enable_pipeline,
   input  logic                                     i_halt_detected,
   // Control bits from execute.
   input  logic                                     i_reg_write,
   input  logic                                     i_mem_read,
   input  logic                                     i_mem_write,
   input  logic                                     i_mem_to_reg,
   input  logic [mem_stage_pkg::SELECT_BITS-1:0]    i_select_bytes,
   input  logic [$clog2(CANT_REGISTROS)-1:0]        i_dest_reg,
   // Byte address and store data.
   input  logic [mem_stage_pkg::WORD_BITS-1:0]      i_alu_result,
   input  logic [mem_stage_pkg::WORD_BITS-1:0]      i_store_data,
   // Towards write-back.
   output logic                                     o_reg_write,
   output logic                                     o_mem_to_reg,
   output logic                                     o_halt_detected,
   output logic [$clog2(CANT_REGISTROS)-1:0]        o_dest_reg,
   output logic [mem_stage_pkg::WORD_BITS-1:0]      o_alu_result,
   output logic [mem_stage_pkg::WORD_BITS-1:0]      o_read_data,
   output logic                                     o_dirty
);

   // Word index width for the RAM and dirty array.
   localparam int INDEX_BITS = $clog2(RAM_DEPTH);

   ////////////////////
   // Address split.
   ////////////////////

   // Higher address bits are ignored so accesses wrap.
   logic [INDEX_BITS-1:0] word_index;
   logic [1:0]            byte_offset;

   assign word_index = i_alu_result[INDEX_BITS+1:2];
   assign byte_offset = i_alu_result[1:0];

   // Memory strobes, frozen during a stall.
   logic write_strobe;
   logic read_strobe;

   assign write_strobe = i_enable_pipeline & i_mem_write;
   assign read_strobe = i_enable_pipeline & i_mem_read;

   // Lane unit and RAM interconnect.
   mem_stage_pkg::mem_word_u                   write_word;
   mem_stage_pkg::mem_word_u                   read_word;
   logic [mem_stage_pkg::BYTE_LANES-1:0]       byte_enable;

   // Offset and select of the last load.
   logic [1:0]                                 load_offset;
   logic [mem_stage_pkg::SELECT_BITS-1:0]      load_select;

   ////////////////////
   // Stage register.
   ////////////////////

   // Control, destination, halt and ALU result advance on every enabled edge.
   // Offset and select advance only with a load, in step with the read register.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write <= 1'b0;
         o_mem_to_reg <= 1'b0;
         o_halt_detected <= 1'b0;
         o_dest_reg <= '0;
         o_alu_result <= '0;
         load_offset <= 2'b00;
         load_select <= mem_stage_pkg::SEL_RESET;
      end else if (i_enable_pipeline) begin
         o_reg_write <= i_reg_write;
         o_mem_to_reg <= i_mem_to_reg;
         o_halt_detected <= i_halt_detected;
         o_dest_reg <= i_dest_reg;
         o_alu_result <= i_alu_result;
         if (i_mem_read) begin
            load_offset <= byte_offset;
            load_select <= i_select_bytes;
         end
      end
   end

   // Store steering and load extension.
   byte_lane_unit u_byte_lane_unit (
      .i_store_data   (i_store_data),
      .i_store_offset (byte_offset),
      .i_store_select (i_select_bytes),
      .o_write_word   (write_word),
      .o_byte_enable  (byte_enable),
      .i_read_word    (read_word),
      .i_load_offset  (load_offset),
      .i_load_select  (load_select),
      .o_load_data    (o_read_data)
   );

   data_memory #(
      .RAM_DEPTH (RAM_DEPTH)
   ) u_data_memory (
      .i_clock        (i_clock),
      .i_soft_reset   (i_soft_reset),
      .i_word_index   (word_index),
      .i_write_word   (write_word),
      .i_byte_enable  (byte_enable),
      .i_write_strobe (write_strobe),
      .i_read_strobe  (read_strobe),
      .o_read_word    (read_word)
   );

   dirty_bit_tracker #(
      .RAM_DEPTH (RAM_DEPTH)
   ) u_dirty_bit_tracker (
      .i_clock        (i_clock),
      .i_soft_reset   (i_soft_reset),
      .i_word_index   (word_index),
      .i_write_strobe (write_strobe),
      .i_read_strobe  (read_strobe),
      .o_dirty        (o_dirty)
   );

   // Decode never issues a load and a store in the same instruction.
   a_no_read_write: assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      i_enable_pipeline |-> !(i_mem_read && i_mem_write)
   ) else $error("top_mem: mem_read and mem_write high together");

   // Misaligned or illegal-size access at issue.
   a_access_aligned: assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      (read_strobe || write_strobe) |->
         (i_select_bytes[1:0] != 2'd2) &&
         (i_select_bytes[1:0] != mem_stage_pkg::SEL_SIZE_HALF || !byte_offset[0]) &&
         (i_select_bytes[1:0] != mem_stage_pkg::SEL_SIZE_WORD || byte_offset == 2'b00)
   ) else $error("top_mem: misaligned memory access");

endmodule

/* sim/tb_top_mem.sv */
`timescale 1ns/1ps

module tb_top_mem;

   localparam int RAM_DEPTH = 1024;
   localparam int CANT_REGISTROS = 32;
   localparam int DEST_BITS = $clog2(CANT_REGISTROS);
   localparam int INDEX_BITS = $clog2(RAM_DEPTH);
   // Falling edges allowed per wait before giving up.
   localparam int WAIT_LIMIT = 4;

   logic i_clock, i_soft_reset, i_enable_pipeline, i_halt_detected;
   logic i_reg_write, i_mem_read, i_mem_write, i_mem_to_reg;
   logic [mem_stage_pkg::SELECT_BITS-1:0] i_select_bytes;
   logic [DEST_BITS-1:0] i_dest_reg, o_dest_reg;
   logic [mem_stage_pkg::WORD_BITS-1:0] i_alu_result, i_store_data, o_alu_result, o_read_data;
   logic o_reg_write, o_mem_to_reg, o_halt_detected, o_dirty;

   // Reference model of the RAM, the dirty bits and the expected outputs.
   logic [31:0] model_mem [RAM_DEPTH];
   logic [RAM_DEPTH-1:0] model_dirty;
   logic exp_reg_write, exp_mem_to_reg, exp_halt, exp_dirty, exp_read_valid;
   logic [DEST_BITS-1:0] exp_dest;
   logic [31:0] exp_alu, exp_read;
   int seed = 73;
   int cycle_count = 0;

   top_mem #(
      .RAM_DEPTH      (RAM_DEPTH),
      .CANT_REGISTROS (CANT_REGISTROS)
   ) dut (.*);

   always #10 i_clock = ~i_clock;

   // Counts rising edges so that waits can tell an edge has passed.
   always @(posedge i_clock) cycle_count <= cycle_count + 1;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_word(input string name, input mem_stage_pkg::mem_word_u got,
                             input mem_stage_pkg::mem_word_u exp);
      if (got.word !== exp.word)
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got.word, exp.word));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_dest(input string name, input logic [DEST_BITS-1:0] got,
                             input logic [DEST_BITS-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Waits for one rising edge and returns at the next falling edge.
   task automatic next_edge();
      int start;
      int polls;
      start = cycle_count;
      polls = 0;
      while (cycle_count == start) begin
         @(negedge i_clock);
         polls++;
         if (polls > WAIT_LIMIT) fail_run("Timeout while waiting for a rising clock edge.");
      end
   endtask

   task automatic check_outputs();
      check_bit("o_reg_write", o_reg_write, exp_reg_write);
      check_bit("o_mem_to_reg", o_mem_to_reg, exp_mem_to_reg);
      check_bit("o_halt_detected", o_halt_detected, exp_halt);
      check_dest("o_dest_reg", o_dest_reg, exp_dest);
      check_word("o_alu_result", o_alu_result, exp_alu);
      check_bit("o_dirty", o_dirty, exp_dirty);
      if (exp_read_valid) check_word("o_read_data", o_read_data, exp_read);
   endtask

   // Holds reset for n cycles.
   // Dirty bits and stage outputs clear while the RAM keeps its data.
   task automatic hold_reset(input int n);
      i_soft_reset = 1'b0;
      i_mem_read = 1'b0;
      i_mem_write = 1'b0;
      for (int i = 0; i < n; i++) next_edge();
      i_soft_reset = 1'b1;
      model_dirty = '0;
      {exp_reg_write, exp_mem_to_reg, exp_halt, exp_dirty, exp_read_valid} = '0;
      exp_dest = '0;
      exp_alu = '0;
      check_outputs();
   endtask

   // Lane value of a loaded word, sign or zero extended.
   function automatic logic [31:0] extract(input logic [31:0] word, input logic [1:0] off,
                                           input logic [2:0] sel);
      logic [31:0] sh;
      sh = word >> (8 * off);
      case (sel[1:0])
         2'd0: return (sel[2] || !sh[7]) ? {24'h0, sh[7:0]} : {24'hffffff, sh[7:0]};
         2'd1: return (sel[2] || !sh[15]) ? {16'h0, sh[15:0]} : {16'hffff, sh[15:0]};
         default: return word;
      endcase
   endfunction

   // Store data merged into the old word at the addressed lanes.
   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                         input logic [1:0] off, input logic [2:0] sel);
      logic [31:0] mask;
      case (sel[1:0])
         2'd0: mask = 32'h0000_00ff << (8 * off);
         2'd1: mask = 32'h0000_ffff << (8 * off);
         default: mask = 32'hffff_ffff;
      endcase
      return (old & ~mask) | ((data << (8 * off)) & mask);
   endfunction

   // One enabled cycle with random control bits, checked one edge later.
   task automatic do_access(input logic rd, input logic wr, input logic [2:0] sel,
                            input logic [31:0] addr, input logic [31:0] data, input logic chk);
      logic [31:0] rnd;
      logic [INDEX_BITS-1:0] idx;
      rnd = $random(seed);
      idx = addr[INDEX_BITS+1:2];
      {i_enable_pipeline, i_mem_read, i_mem_write} = {1'b1, rd, wr};
      {i_select_bytes, i_alu_result, i_store_data} = {sel, addr, data};
      {i_reg_write, i_mem_to_reg, i_halt_detected} = rnd[2:0];
      i_dest_reg = rnd[DEST_BITS+2:3];
      {exp_reg_write, exp_mem_to_reg, exp_halt} = rnd[2:0];
      exp_dest = rnd[DEST_BITS+2:3];
      exp_alu = addr;
      if (rd || wr) exp_dirty = model_dirty[idx];
      if (rd) begin
         exp_read = extract(model_mem[idx], addr[1:0], sel);
         exp_read_valid = chk;
      end
      if (wr) begin
         model_mem[idx] = merge(model_mem[idx], data, addr[1:0], sel);
         model_dirty[idx] = 1'b1;
      end
      next_edge();
      check_outputs();
      i_mem_read = 1'b0;
      i_mem_write = 1'b0;
   endtask

   ////////////////////
   // Directed tests.
   ////////////////////

   // Loads of untouched words report clean.
   task automatic test_reset_state();
      for (int i = 0; i < 4; i++) do_access(1'b1, 1'b0, 3'b011, $random(seed) & ~32'h3, 0, 1'b0);
   endtask

   task automatic test_word_roundtrip();
      logic [31:0] addr;
      for (int i = 0; i < 8; i++) begin
         addr = $random(seed) & ~32'h3;
         do_access(1'b0, 1'b1, 3'b011, addr, $random(seed), 1'b0);
         do_access(1'b1, 1'b0, 3'b011, addr, 32'h0, 1'b1);
      end
   endtask

   // Byte then half stores, each lane read back signed and unsigned.
   task automatic test_lane_merge();
      logic [31:0] base;
      base = $random(seed) & ~32'h3;
      do_access(1'b0, 1'b1, 3'b011, base, $random(seed), 1'b0);
      for (int lane = 0; lane < 4; lane++)
         do_access(1'b0, 1'b1, 3'b000, base + lane, $random(seed), 1'b0);
      for (int lane = 0; lane < 8; lane++)
         do_access(1'b1, 1'b0, {lane[2], 2'b00}, base + lane[1:0], 32'h0, 1'b1);
      for (int h = 0; h < 2; h++)
         do_access(1'b0, 1'b1, 3'b001, base + 2 * h, $random(seed), 1'b0);
      for (int h = 0; h < 4; h++)
         do_access(1'b1, 1'b0, {h[1], 2'b01}, base + 2 * h[0], 32'h0, 1'b1);
      do_access(1'b1, 1'b0, 3'b011, base, 32'h0, 1'b1);
   endtask

   // No memory access; dirty and read data hold.
   task automatic test_pass_through();
      for (int i = 0; i < 4; i++) do_access(1'b0, 1'b0, 3'b011, $random(seed), 0, 1'b0);
   endtask

   task automatic test_stall();
      logic [31:0] addr;
      addr = $random(seed) & ~32'h3;
      do_access(1'b0, 1'b1, 3'b011, addr, $random(seed), 1'b0);
      // Move the ALU result away from the store address first.
      do_access(1'b0, 1'b0, 3'b011, ~addr, 0, 1'b0);
      // Store with changed controls while frozen.
      {i_enable_pipeline, i_mem_write, i_alu_result} = {1'b0, 1'b1, addr};
      {i_reg_write, i_mem_to_reg, i_halt_detected} = ~{exp_reg_write, exp_mem_to_reg, exp_halt};
      i_store_data = ~model_mem[addr[INDEX_BITS+1:2]];
      i_dest_reg = ~exp_dest;
      next_edge();
      next_edge();
      check_outputs();
      i_mem_write = 1'b0;
      do_access(1'b1, 1'b0, 3'b011, addr, 32'h0, 1'b1);
   endtask

   task automatic test_mid_reset();
      logic [31:0] addrs [3];
      for (int i = 0; i < 3; i++) begin
         addrs[i] = ($random(seed) & 32'h0000_0ff0) | (i << 2);
         do_access(1'b0, 1'b1, 3'b011, addrs[i], $random(seed), 1'b0);
      end
      hold_reset(4);
      for (int i = 0; i < 3; i++) do_access(1'b1, 1'b0, 3'b011, addrs[i], 32'h0, 1'b1);
   endtask

   initial begin
      i_clock = 1'b0;
      {i_enable_pipeline, i_halt_detected, i_reg_write, i_mem_to_reg} = '0;
      {i_mem_read, i_mem_write, i_dest_reg, i_alu_result, i_store_data} = '0;
      i_select_bytes = 3'b011;
      hold_reset(4);
      test_reset_state();
      test_word_roundtrip();
      test_lane_merge();
      test_pass_through();
      test_stall();
      test_mid_reset();
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* compile.f */
design/mem_stage_pkg.sv
design/data_memory.sv
design/dirty_bit_tracker.sv
design/byte_lane_unit.sv
design/top_mem.sv
sim/tb_top_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f compile.f \
   --top-module tb_top_mem \
   -o tb_top_mem

# Exit status is nonzero when the testbench stops on $fatal.
./obj_dir/tb_top_mem
